//--- alu.sv
//////////////////////////////////////////////////////////////////////
// Arithmetic and logic unit.
// Ten RV32I operations, pass-through of b, and an a == b flag.
//////////////////////////////////////////////////////////////////////

module alu import rv_core_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    eq
);

	logic [4:0] shamt;

	assign shamt = b[4:0]; // only the low five bits count for 32-bit shifts.

	always_comb begin
		case (op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_XOR:    result = a ^ b;
			ALU_SLL:    result = a << shamt;
			ALU_SRL:    result = a >> shamt;
			ALU_SRA:    result = word_t'($signed(a) >>> shamt);
			ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU:   result = {31'd0, a < b};
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

	// branches compare on the raw operands.
	assign eq = (a == b);

endmodule

//--- core_control.sv
//////////////////////////////////////////////////////////////////////
// Instruction decoder.
// Steers the ALU, operand and write-back muxes and the next-PC kind.
//////////////////////////////////////////////////////////////////////

module core_control import rv_isa_pkg::*, rv_core_pkg::*; (
	input  instr_t    instr,
	output alu_op_t   alu_op,
	output logic      alu_src_imm,
	output logic      reg_we,
	output wb_sel_t   wb_sel,
	output br_kind_t  br_kind,
	output imm_kind_t imm_kind
);

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		// anything not matched below retires as a no-op.
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		reg_we      = 1'b0;
		wb_sel      = WB_ALU;
		br_kind     = BR_NONE;
		imm_kind    = IMM_I;
		case (opcode)
			OP_REG: begin
				reg_we = 1'b1;
				case (funct3)
					F3_ADD_SUB: alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
					F3_SLL:     alu_op = ALU_SLL;
					F3_SLT:     alu_op = ALU_SLT;
					F3_SLTU:    alu_op = ALU_SLTU;
					F3_XOR:     alu_op = ALU_XOR;
					F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
					F3_OR:      alu_op = ALU_OR;
					default:    alu_op = ALU_AND;
				endcase
				// only SUB and SRA may carry the alternate funct7.
				if (funct7 != F7_BASE &&
				    !(funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)))
					reg_we = 1'b0;
			end
			OP_IMM: begin
				alu_src_imm = 1'b1;
				reg_we      = 1'b1;
				case (funct3)
					F3_ADD_SUB: alu_op = ALU_ADD;
					F3_SLT:     alu_op = ALU_SLT;
					F3_XOR:     alu_op = ALU_XOR;
					F3_OR:      alu_op = ALU_OR;
					F3_AND:     alu_op = ALU_AND;
					default:    reg_we = 1'b0; // immediate shifts and SLTIU are not built.
				endcase
			end
			OP_LUI: begin
				alu_op      = ALU_PASS_B;
				alu_src_imm = 1'b1;
				reg_we      = 1'b1;
				imm_kind    = IMM_U;
			end
			OP_JAL: begin
				reg_we   = 1'b1;
				wb_sel   = WB_LINK;
				br_kind  = BR_JAL;
				imm_kind = IMM_J;
			end
			OP_BRANCH: begin
				alu_op   = ALU_SUB; // the compare runs on the ALU equality flag.
				imm_kind = IMM_B;
				if (funct3 == F3_BEQ)
					br_kind = BR_EQ;
				else if (funct3 == F3_BNE)
					br_kind = BR_NE;
			end
			default: begin
				reg_we = 1'b0;
			end
		endcase
	end

endmodule

//--- imm_gen.sv
//////////////////////////////////////////////////////////////////////
// Immediate generator.
// Rebuilds and sign-extends the I, U, B and J immediates.
//////////////////////////////////////////////////////////////////////

module imm_gen import rv_isa_pkg::*, rv_core_pkg::*; (
	input  instr_t    instr,
	input  imm_kind_t imm_kind,
	output word_t     imm
);

	always_comb begin
		case (imm_kind)
			IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
			IMM_U: imm = {instr[31:12], 12'd0};
			IMM_B: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			default: begin
				// J format, bit 0 is always zero.
				imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
		endcase
	end

endmodule

//--- pc_unit.sv
//////////////////////////////////////////////////////////////////////
// Program counter.
// Steps by 4 or jumps to PC plus immediate on each executed instruction.
//////////////////////////////////////////////////////////////////////

`include "rv_core_settings.svh"

module pc_unit import rv_core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     step,
	input  br_kind_t br_kind,
	input  logic     eq,
	input  word_t    imm,
	output word_t    pc,
	output word_t    pc_plus4
);

	logic  take;
	word_t target;

	always_comb begin
		case (br_kind)
			BR_EQ:   take = eq;
			BR_NE:   take = !eq;
			BR_JAL:  take = 1'b1;
			default: take = 1'b0;
		endcase
	end

	assign pc_plus4 = pc + word_t'(4);
	assign target   = pc + imm;

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RESET_PC;
		else if (step)
			pc <= take ? target : pc_plus4; // held while no instruction arrives.
	end

endmodule

//--- reg_file.sv
//////////////////////////////////////////////////////////////////////
// Integer register file.
// Two combinational read ports, one write port, x0 reads as zero.
//////////////////////////////////////////////////////////////////////

`include "rv_core_settings.svh"

module reg_file import rv_isa_pkg::*, rv_core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     wr_en,
	input  reg_idx_t addr_wr,
	input  reg_idx_t addr_rd1,
	input  reg_idx_t addr_rd2,
	input  word_t    data_wr,
	output word_t    data_rd1,
	output word_t    data_rd2
);

	// x0 has no storage behind it.
	word_t regs [1:`REG_COUNT-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && addr_wr != '0) begin
			regs[addr_wr] <= data_wr;
		end
	end

	// a write shows up on the read ports right after its edge.
	assign data_rd1 = (addr_rd1 == '0) ? '0 : regs[addr_rd1];
	assign data_rd2 = (addr_rd2 == '0) ? '0 : regs[addr_rd2];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the RV32I core testbench with Verilator, run it and check sim.log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_rv_core \
	-f rv_core.f -o sim_rv_core || { echo "build failed"; exit 1; }
./obj_dir/sim_rv_core +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "simulator exited with an error status" >> sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"

//--- rv_core.f
+incdir+.
rv_isa_pkg.sv
rv_core_pkg.sv
core_control.sv
reg_file.sv
alu.sv
imm_gen.sv
pc_unit.sv
rv_core_top.sv
rv_core_assert.sv
tb_core_checker.sv
tb_rv_core.sv

//--- rv_core_assert.sv
//////////////////////////////////////////////////////////////////////
// Concurrent assertions on the core's fetch and retire ports.
//////////////////////////////////////////////////////////////////////

module rv_core_assert import rv_isa_pkg::*, rv_core_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     instr_valid,
	input word_t    instr_addr,
	input logic     wb_valid,
	input reg_idx_t wb_rd
);
	timeunit 1ns;
	timeprecision 1ns;

	int fail_count;

	initial fail_count = 0;

	quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !wb_valid)
		else begin fail_count++; $error("wb_valid high in the cycle after reset"); end

	retire_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> wb_rd != '0)
		else begin fail_count++; $error("retire record names x0"); end

	pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		instr_addr[1:0] == 2'b00)
		else begin fail_count++; $error("instr_addr is not word aligned"); end

	pc_held_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!instr_valid |=> $stable(instr_addr))
		else begin fail_count++; $error("instr_addr moved without an instruction"); end

endmodule

bind rv_core_top rv_core_assert u_assert (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.instr_addr  (instr_addr),
	.wb_valid    (wb_valid),
	.wb_rd       (wb_rd)
);

//--- rv_core_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I core internal types.
// Data words, ALU operation codes, write-back and next-PC selects.
//////////////////////////////////////////////////////////////////////

`include "rv_core_settings.svh"

package rv_core_pkg;

	typedef logic [`XLEN-1:0] word_t;

	typedef logic [3:0] alu_op_t;
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_AND    = 4'd2;
	localparam alu_op_t ALU_OR     = 4'd3;
	localparam alu_op_t ALU_XOR    = 4'd4;
	localparam alu_op_t ALU_SLL    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_SLT    = 4'd8;
	localparam alu_op_t ALU_SLTU   = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10; // used by LUI.

	typedef logic [1:0] wb_sel_t;
	localparam wb_sel_t WB_ALU  = 2'd0;
	localparam wb_sel_t WB_LINK = 2'd1; // pc plus 4.

	typedef logic [1:0] br_kind_t;
	localparam br_kind_t BR_NONE = 2'd0;
	localparam br_kind_t BR_EQ   = 2'd1;
	localparam br_kind_t BR_NE   = 2'd2;
	localparam br_kind_t BR_JAL  = 2'd3;

endpackage

//--- rv_core_settings.svh
//////////////////////////////////////////////////////////////////////
// RV32I core build settings.
// Data width, register file geometry and the PC value after reset.
//////////////////////////////////////////////////////////////////////

`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// architectural data and address width.
`define XLEN 32

// register file geometry, x0 included in the count.
`define REG_COUNT 32
`define REG_ADDR_W 5

// first fetch address once reset is released.
`define RESET_PC 32'h0000_0000

`endif

//--- rv_core_top.sv
//////////////////////////////////////////////////////////////////////
// Single-cycle RV32I core, top level.
// Joins decoder and datapath and registers the retire record.
//////////////////////////////////////////////////////////////////////

module rv_core_top import rv_isa_pkg::*, rv_core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     instr_valid,
	input  instr_t   instr,
	output word_t    instr_addr,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output word_t    wb_data
);

	alu_op_t   alu_op;
	logic      alu_src_imm;
	logic      reg_we;
	wb_sel_t   wb_sel;
	br_kind_t  br_kind;
	imm_kind_t imm_kind;

	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    imm;
	word_t    rs1_data;
	word_t    rs2_data;
	word_t    alu_b;
	word_t    alu_result;
	logic     alu_eq;
	word_t    pc_plus4;
	word_t    rd_data;
	logic     rd_we;

	assign rd  = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	core_control u_control (
		.instr       (instr),
		.alu_op      (alu_op),
		.alu_src_imm (alu_src_imm),
		.reg_we      (reg_we),
		.wb_sel      (wb_sel),
		.br_kind     (br_kind),
		.imm_kind    (imm_kind)
	);

	imm_gen u_imm (
		.instr    (instr),
		.imm_kind (imm_kind),
		.imm      (imm)
	);

	assign rd_we   = instr_valid && reg_we;
	assign rd_data = (wb_sel == WB_LINK) ? pc_plus4 : alu_result;

	reg_file u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_en    (rd_we),
		.addr_wr  (rd),
		.addr_rd1 (rs1),
		.addr_rd2 (rs2),
		.data_wr  (rd_data),
		.data_rd1 (rs1_data),
		.data_rd2 (rs2_data)
	);

	assign alu_b = alu_src_imm ? imm : rs2_data;

	alu u_alu (
		.op     (alu_op),
		.a      (rs1_data),
		.b      (alu_b),
		.result (alu_result),
		.eq     (alu_eq)
	);

	pc_unit u_pc (
		.clk      (clk),
		.rst_n    (rst_n),
		.step     (instr_valid),
		.br_kind  (br_kind),
		.eq       (alu_eq),
		.imm      (imm),
		.pc       (instr_addr),
		.pc_plus4 (pc_plus4)
	);

	// one retire record per executed write to a register other than x0.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
		end else begin
			wb_valid <= rd_we && rd != '0;
			if (instr_valid) begin
				wb_rd   <= rd;
				wb_data <= rd_data;
			end
		end
	end

endmodule

//--- rv_isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// RV32I instruction set types.
// Instruction fields, opcodes and funct codes of the supported subset.
//////////////////////////////////////////////////////////////////////

`include "rv_core_settings.svh"

package rv_isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// immediate formats the decoder can ask for.
	typedef logic [1:0] imm_kind_t;
	localparam imm_kind_t IMM_I = 2'd0;
	localparam imm_kind_t IMM_U = 2'd1;
	localparam imm_kind_t IMM_B = 2'd2;
	localparam imm_kind_t IMM_J = 2'd3;

	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_BRANCH = 7'b1100011;

	localparam funct3_t F3_ADD_SUB = 3'b000; // also ADDI.
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010; // also SLTI.
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100; // also XORI.
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110; // also ORI.
	localparam funct3_t F3_AND     = 3'b111; // also ANDI.

	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;

	// funct7 selects SUB and SRA over ADD and SRL.
	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

//--- tb_core_checker.sv
//////////////////////////////////////////////////////////////////////
// Retire and fetch port checker.
// Compares wb_* and instr_addr with the expected row and counts errors.
//////////////////////////////////////////////////////////////////////

`include "rv_core_settings.svh"

module tb_core_checker import rv_isa_pkg::*, rv_core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     instr_valid,
	input  word_t    instr_addr,
	input  logic     wb_valid,
	input  reg_idx_t wb_rd,
	input  word_t    wb_data,
	input  int       row,
	input  logic     exp_wb,
	input  reg_idx_t exp_rd,
	input  word_t    exp_data,
	input  word_t    exp_pc,
	output int       error_count,
	output int       check_count
);
	timeunit 1ns;
	timeprecision 1ns;

	logic     live;
	logic     exec;
	int       exec_row;
	logic     pend_wb;
	reg_idx_t pend_rd;
	word_t    pend_data;
	word_t    pc_held; // where instr_addr has to sit until the next strobe.

	initial begin
		live        = 1'b0;
		exec        = 1'b0;
		exec_row    = -1;
		pc_held     = `RESET_PC;
		error_count = 0;
		check_count = 0;
	end

	always @(posedge clk) begin
		live <= rst_n;
		exec <= rst_n && instr_valid;
		if (!rst_n) begin
			pc_held <= `RESET_PC;
		end else if (instr_valid) begin
			exec_row  <= row;
			pend_wb   <= exp_wb;
			pend_rd   <= exp_rd;
			pend_data <= exp_data;
			pc_held   <= exp_pc;
		end
	end

	// the DUT updates on the rising edge, so its outputs are stable here.
	always @(negedge clk) begin
		if (live) begin
			check_count++;
			if (exec && pend_wb) begin
				if (wb_valid !== 1'b1) begin
					$display("row %0d should retire but wb_valid stayed low", exec_row);
					error_count++;
				end else begin
					if (wb_rd !== pend_rd) begin
						$display("MISMATCH row %0d wb_rd: got 0x%02h, expected 0x%02h",
							exec_row, wb_rd, pend_rd);
						error_count++;
					end
					if (wb_data !== pend_data) begin
						$display("MISMATCH row %0d wb_data: got 0x%08h, expected 0x%08h",
							exec_row, wb_data, pend_data);
						error_count++;
					end
				end
			end else if (wb_valid !== 1'b0) begin
				if (exec)
					$display("row %0d writes no register but wb_valid went high", exec_row);
				else
					$display("wb_valid went high at %0t with no instruction executed", $time);
				error_count++;
			end
			if (instr_addr !== pc_held) begin
				$display("MISMATCH instr_addr after row %0d: got 0x%08h, expected 0x%08h",
					exec_row, instr_addr, pc_held);
				error_count++;
			end
		end
	end

endmodule

//--- tb_rv_core.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the single-cycle RV32I core.
// Clock generator, program table, stimulus loop and watchdog.
//////////////////////////////////////////////////////////////////////

module tb_clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ns;

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

endmodule

module tb_rv_core import rv_isa_pkg::*, rv_core_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 3;
	localparam int BURST_START  = 20; // rows from here on are strobed back to back.
	localparam logic [31:0] SEED = 32'h5dd0_e0b9;

	typedef struct packed {
		instr_t   instr;
		logic     wb;
		reg_idx_t rd;
		word_t    data;
		word_t    next_pc;
	} row_t;

	logic     clk;
	logic     rst_n;
	logic     instr_valid;
	instr_t   instr;
	word_t    instr_addr;
	logic     wb_valid;
	reg_idx_t wb_rd;
	word_t    wb_data;

	int       row;
	logic     exp_wb;
	reg_idx_t exp_rd;
	word_t    exp_data;
	word_t    exp_pc;
	int       error_count;
	int       check_count;

	logic [31:0] lfsr;
	row_t        prog[$];
	int          prog_len = 0;

	tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

	rv_core_top dut0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	tb_core_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_addr  (instr_addr),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.row         (row),
		.exp_wb      (exp_wb),
		.exp_rd      (exp_rd),
		.exp_data    (exp_data),
		.exp_pc      (exp_pc),
		.error_count (error_count),
		.check_count (check_count)
	);

	function automatic instr_t reg_op(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic instr_t imm_op(input logic [11:0] imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic instr_t lui_op(input logic [19:0] imm, input reg_idx_t rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic instr_t branch_op(input logic [12:0] off, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic instr_t jal_op(input logic [20:0] off, input reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] value);
		value = '0;
		repeat (n) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr_step(lfsr);
		end
	endtask

	function automatic void add_row(input instr_t i, input logic wb, input reg_idx_t rd,
			input word_t data, input word_t next_pc);
		row_t r;
		r.instr   = i;
		r.wb      = wb;
		r.rd      = rd;
		r.data    = data;
		r.next_pc = next_pc;
		prog.push_back(r);
	endfunction

	function automatic void load_program();
		add_row(reg_op(7'h00, 0, 5, 3'b000, 1), 1, 1, 32'h0000_0000, 32'd4); // x5 after reset.
		add_row(imm_op(12'd12, 0, 3'b000, 1), 1, 1, 32'h0000_000C, 32'd8);
		add_row(imm_op(12'hFFD, 0, 3'b000, 2), 1, 2, 32'hFFFF_FFFD, 32'd12);
		add_row(lui_op(20'h80000, 3), 1, 3, 32'h8000_0000, 32'd16);
		add_row(reg_op(7'h00, 2, 1, 3'b000, 4), 1, 4, 32'h0000_0009, 32'd20);
		add_row(reg_op(7'h20, 2, 1, 3'b000, 5), 1, 5, 32'h0000_000F, 32'd24);
		add_row(reg_op(7'h20, 1, 2, 3'b000, 6), 1, 6, 32'hFFFF_FFF1, 32'd28);
		add_row(reg_op(7'h00, 2, 1, 3'b111, 7), 1, 7, 32'h0000_000C, 32'd32);
		add_row(reg_op(7'h00, 2, 1, 3'b110, 8), 1, 8, 32'hFFFF_FFFD, 32'd36);
		add_row(reg_op(7'h00, 2, 1, 3'b100, 9), 1, 9, 32'hFFFF_FFF1, 32'd40);
		add_row(reg_op(7'h00, 1, 2, 3'b001, 10), 1, 10, 32'hFFFF_D000, 32'd44);
		add_row(reg_op(7'h00, 1, 3, 3'b101, 11), 1, 11, 32'h0008_0000, 32'd48);
		add_row(reg_op(7'h20, 1, 3, 3'b101, 12), 1, 12, 32'hFFF8_0000, 32'd52);
		add_row(reg_op(7'h00, 1, 2, 3'b010, 13), 1, 13, 32'h0000_0001, 32'd56);
		add_row(reg_op(7'h00, 1, 2, 3'b011, 14), 1, 14, 32'h0000_0000, 32'd60);
		add_row(imm_op(12'hFFE, 2, 3'b010, 15), 1, 15, 32'h0000_0001, 32'd64);
		add_row(imm_op(12'h0F0, 2, 3'b111, 16), 1, 16, 32'h0000_00F0, 32'd68);
		add_row(imm_op(12'h700, 1, 3'b110, 17), 1, 17, 32'h0000_070C, 32'd72);
		add_row(imm_op(12'hFFF, 2, 3'b100, 18), 1, 18, 32'h0000_0002, 32'd76);
		add_row(imm_op(12'd5, 1, 3'b000, 0), 0, 0, 32'h0, 32'd80); // write to x0 is dropped.
		add_row(reg_op(7'h00, 0, 0, 3'b000, 19), 1, 19, 32'h0000_0000, 32'd84);
		add_row(branch_op(13'd16, 4, 1, 3'b000), 0, 0, 32'h0, 32'd88); // beq not taken.
		add_row(branch_op(13'd12, 1, 1, 3'b000), 0, 0, 32'h0, 32'd100);
		add_row(branch_op(13'd8, 1, 1, 3'b001), 0, 0, 32'h0, 32'd104); // bne not taken.
		add_row(branch_op(13'h1FF8, 2, 1, 3'b001), 0, 0, 32'h0, 32'd96);
		add_row(jal_op(21'd32, 20), 1, 20, 32'h0000_0064, 32'd128);
		add_row(jal_op(21'h1FFF80, 0), 0, 0, 32'h0, 32'd0);
		add_row(imm_op(12'd4, 20, 3'b000, 21), 1, 21, 32'h0000_0068, 32'd4);
		add_row(reg_op(7'h00, 3, 12, 3'b000, 22), 1, 22, 32'h7FF8_0000, 32'd8);
		add_row(32'h0000_00F3, 0, 0, 32'h0, 32'd12); // system opcode, not built.
		add_row(reg_op(7'h00, 13, 15, 3'b000, 23), 1, 23, 32'h0000_0002, 32'd16);
	endfunction

	initial begin
		logic [31:0] bits;
		logic [31:0] junk;
		int          gap;
		int          total;
		lfsr        = SEED;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		row         = -1;
		exp_wb      = 1'b0;
		exp_rd      = '0;
		exp_data    = '0;
		exp_pc      = '0;
		load_program();
		prog_len = prog.size();
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		foreach (prog[i]) begin
			instr_valid = 1'b1;
			instr       = prog[i].instr;
			row         = i;
			exp_wb      = prog[i].wb;
			exp_rd      = prog[i].rd;
			exp_data    = prog[i].data;
			exp_pc      = prog[i].next_pc;
			@(negedge clk);
			instr_valid = 1'b0;
			gap = 0;
			if (i < BURST_START) begin
				random_bits(2, bits);
				gap = int'(bits % 3);
			end
			repeat (gap) begin
				random_bits(32, junk);
				instr = junk; // idle garbage on the bus must not execute.
				@(negedge clk);
			end
		end
		repeat (2) @(negedge clk);
		#(CLK_PERIOD / 4);
		total = error_count + dut0.u_assert.fail_count;
		$display("checks %0d, checker errors %0d, assertion failures %0d",
			check_count, error_count, dut0.u_assert.fail_count);
		if (total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// each row needs at most three cycles including its idle gap.
	initial begin
		int limit;
		wait (prog_len > 0);
		limit = prog_len * 4 + RESET_CYCLES;
		#(limit * CLK_PERIOD);
		$display("timeout: the program did not complete within %0d clock cycles", limit);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
